//--- Bender.yml
package:
  name: dmr_ctrl

sources:
  - include_dirs:
      - source
    files:
      - source/dmr_mode_pkg.sv
      - source/dmr_reg_pkg.sv
      - source/dmr_lockstep_compare.sv
      - source/dmr_recovery_timer.sv
      - source/dmr_mode_fsm.sv
      - source/dmr_cfg_regs.sv
      - source/dmr_ctrl_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_dmr_ctrl.sv

//--- all.f
+incdir+source
source/dmr_mode_pkg.sv
source/dmr_reg_pkg.sv
source/dmr_lockstep_compare.sv
source/dmr_recovery_timer.sv
source/dmr_mode_fsm.sv
source/dmr_cfg_regs.sv
source/dmr_ctrl_top.sv
verif/tb_clk_gen.sv
verif/tb_dmr_ctrl.sv

//--- source/dmr_cfg_regs.sv
/*
 * DMR configuration registers
 * Enable bit, mode status readout and saturating mismatch counter
 */
`timescale 1ns/1ps
`default_nettype none

`include "dmr_defines.svh"

module dmr_cfg_regs (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     reg_valid_i,
  input  wire logic                     reg_write_i,
  input  wire dmr_reg_pkg::reg_addr_t   reg_addr_i,
  input  wire dmr_reg_pkg::reg_data_t   reg_wdata_i,
  output dmr_reg_pkg::reg_data_t        reg_rdata_o,
  output logic                          reg_rvalid_o,
  input  wire logic                     ext_enable_i,
  input  wire logic                     ext_enable_we_i,
  input  wire dmr_mode_pkg::dmr_mode_e  mode_i,
  input  wire logic                     incr_mismatch_i,
  output logic                          dmr_enable_o
);

  logic                      enable_q;
  logic [`DMR_CNT_WIDTH-1:0] cnt_q;
  logic                      wr_ctrl, cnt_clr, rd_req;
  dmr_reg_pkg::ctrl_reg_t    wdata_ctrl, ctrl_rd;
  dmr_reg_pkg::status_reg_t  status_rd;
  dmr_reg_pkg::reg_data_t    rdata_d;

  // Bus decode, one strobe per access
  assign wr_ctrl = reg_valid_i && reg_write_i && (reg_addr_i == dmr_reg_pkg::REG_CTRL);
  assign cnt_clr = reg_valid_i && reg_write_i && (reg_addr_i == dmr_reg_pkg::REG_MISMATCH);
  assign rd_req  = reg_valid_i && !reg_write_i;
  assign wdata_ctrl = dmr_reg_pkg::ctrl_reg_t'(reg_wdata_i);

  // External enable update wins over the bus
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q <= 1'(`DMR_DEFAULT_ON);
    end else if (ext_enable_we_i) begin
      enable_q <= ext_enable_i;
    end else if (wr_ctrl) begin
      enable_q <= wdata_ctrl.enable;
    end
  end

  // Any write clears, increments stop at all ones
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cnt_clr) begin
      cnt_q <= '0;
    end else if (incr_mismatch_i && (cnt_q != '1)) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Read mux
  always_comb begin
    ctrl_rd          = '0;
    ctrl_rd.enable   = enable_q;
    status_rd        = '0;
    status_rd.mode   = mode_i;
    case (reg_addr_i)
      dmr_reg_pkg::REG_CTRL:     rdata_d = ctrl_rd;
      dmr_reg_pkg::REG_STATUS:   rdata_d = status_rd;
      dmr_reg_pkg::REG_MISMATCH: rdata_d = dmr_reg_pkg::reg_data_t'(cnt_q);
      default:                   rdata_d = '0;
    endcase
  end

  // Read response one cycle after the request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reg_rvalid_o <= 1'b0;
    end else begin
      reg_rvalid_o <= rd_req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      reg_rdata_o <= rdata_d;
    end
  end

  assign dmr_enable_o = enable_q;

  // Only a software clear may lower the count, so it never wraps
  a_cnt_no_wrap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !cnt_clr |=> (cnt_q >= $past(cnt_q)));

endmodule

`default_nettype wire

//--- source/dmr_ctrl_top.sv
/*
 * DMR lockstep control top
 * Registers, fetch and store comparators, mode FSM and recovery timer
 */
`timescale 1ns/1ps
`default_nettype none

module dmr_ctrl_top (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // Register port
  input  wire logic                    reg_valid_i,
  input  wire logic                    reg_write_i,
  input  wire dmr_reg_pkg::reg_addr_t  reg_addr_i,
  input  wire dmr_reg_pkg::reg_data_t  reg_wdata_i,
  output dmr_reg_pkg::reg_data_t       reg_rdata_o,
  output logic                         reg_rvalid_o,
  // Enable from an outside controller
  input  wire logic                    ext_enable_i,
  input  wire logic                    ext_enable_we_i,
  input  wire logic                    fetch_en_i,
  input  wire logic                    cores_synch_i,
  // Fetch streams of cores A and B
  input  wire logic                    fetch_a_valid_i,
  input  wire dmr_mode_pkg::fetch_t    fetch_a_addr_i,
  input  wire logic                    fetch_b_valid_i,
  input  wire dmr_mode_pkg::fetch_t    fetch_b_addr_i,
  // Store streams of cores A and B
  input  wire logic                    store_a_valid_i,
  input  wire dmr_mode_pkg::store_t    store_a_i,
  input  wire logic                    store_b_valid_i,
  input  wire dmr_mode_pkg::store_t    store_b_i,
  output logic                         setback_o,
  output logic                         recovery_request_o,
  output logic                         grp_in_independent_o,
  output dmr_mode_pkg::dmr_mode_e      mode_o
);

  logic fetch_mismatch, store_mismatch, dmr_error;
  logic dmr_enable, incr_mismatch, recovery_finished;

  dmr_cfg_regs i_regs (
    .clk_i, .rst_ni, .reg_valid_i, .reg_write_i, .reg_addr_i, .reg_wdata_i,
    .reg_rdata_o, .reg_rvalid_o, .ext_enable_i, .ext_enable_we_i,
    .mode_i(mode_o), .incr_mismatch_i(incr_mismatch), .dmr_enable_o(dmr_enable)
  );

  dmr_lockstep_compare #(.payload_t(dmr_mode_pkg::fetch_t)) i_fetch_cmp (
    .clk_i, .rst_ni,
    .a_valid_i(fetch_a_valid_i), .a_payload_i(fetch_a_addr_i),
    .b_valid_i(fetch_b_valid_i), .b_payload_i(fetch_b_addr_i),
    .mismatch_o(fetch_mismatch)
  );

  dmr_lockstep_compare #(.payload_t(dmr_mode_pkg::store_t)) i_store_cmp (
    .clk_i, .rst_ni,
    .a_valid_i(store_a_valid_i), .a_payload_i(store_a_i),
    .b_valid_i(store_b_valid_i), .b_payload_i(store_b_i),
    .mismatch_o(store_mismatch)
  );

  // Either stream diverging is a lockstep error
  assign dmr_error = fetch_mismatch | store_mismatch;

  dmr_mode_fsm i_fsm (
    .clk_i, .rst_ni, .dmr_enable_i(dmr_enable), .fetch_en_i, .cores_synch_i,
    .dmr_error_i(dmr_error), .recovery_finished_i(recovery_finished),
    .mode_o, .setback_o, .recovery_request_o, .incr_mismatch_o(incr_mismatch)
  );

  // Stands in for the external recovery unit
  dmr_recovery_timer i_timer (
    .clk_i, .rst_ni, .start_i(recovery_request_o), .busy_o(), .done_o(recovery_finished)
  );

  assign grp_in_independent_o = (mode_o == dmr_mode_pkg::NON_DMR);

endmodule

`default_nettype wire

//--- source/dmr_defines.svh
/*
 * DMR lockstep control configuration
 * Widths, restore length and the redundancy mode options
 */
`ifndef DMR_DEFINES_SVH
`define DMR_DEFINES_SVH

// Fetch and store address width
`define DMR_ADDR_WIDTH 32
// Store data width
`define DMR_DATA_WIDTH 32
// Saturating mismatch counter width
`define DMR_CNT_WIDTH 16
// Restore length in cycles, from recovery request to finish
`define DMR_RECOVERY_CYCLES 8
// 1 keeps the pair in lockstep, software cannot split it
`define DMR_FIXED 0
// Reset value of the enable bit, also picks the reset mode
`define DMR_DEFAULT_ON 0
// 1 sends a run-mode mismatch into restore
`define DMR_RAPID_RECOVERY 1

`endif

//--- source/dmr_lockstep_compare.sv
/*
 * Lockstep comparator
 * Registered check of one transaction stream from two cores,
 * payload type chosen per instance
 */
`timescale 1ns/1ps
`default_nettype none

module dmr_lockstep_compare #(
  parameter type payload_t = logic
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     a_valid_i,
  input  wire payload_t a_payload_i,
  input  wire logic     b_valid_i,
  input  wire payload_t b_payload_i,
  output logic          mismatch_o
);

  logic valid_diff, payload_diff, mismatch_d;

  // One core issued a transaction the other did not
  assign valid_diff = a_valid_i ^ b_valid_i;

  // Payloads only matter when both sides are valid
  assign payload_diff = a_valid_i && b_valid_i && (a_payload_i != b_payload_i);

  assign mismatch_d = valid_diff || payload_diff;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mismatch_o <= 1'b0;
    end else begin
      mismatch_o <= mismatch_d;
    end
  end

endmodule

`default_nettype wire

//--- source/dmr_mode_fsm.sv
/*
 * DMR mode state machine
 * Switches the pair between independent, lockstep run and restore,
 * and issues setback, recovery request and mismatch count pulses
 */
`timescale 1ns/1ps
`default_nettype none

`include "dmr_defines.svh"

module dmr_mode_fsm (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 dmr_enable_i,
  input  wire logic                 fetch_en_i,
  input  wire logic                 cores_synch_i,
  input  wire logic                 dmr_error_i,
  input  wire logic                 recovery_finished_i,
  output dmr_mode_pkg::dmr_mode_e   mode_o,
  output logic                      setback_o,
  output logic                      recovery_request_o,
  output logic                      incr_mismatch_o
);

  localparam dmr_mode_pkg::dmr_mode_e ResetMode =
    (`DMR_DEFAULT_ON != 0) ? dmr_mode_pkg::DMR_RUN : dmr_mode_pkg::NON_DMR;

  dmr_mode_pkg::dmr_mode_e mode_d, mode_q;
  logic restore_d, incr_d;

  always_comb begin
    mode_d = mode_q;
    incr_d = 1'b0;

    case (mode_q)
      dmr_mode_pkg::DMR_RUN: begin
        // Every run-mode error is counted
        if (dmr_error_i) begin
          incr_d = 1'b1;
          if (`DMR_RAPID_RECOVERY != 0) begin
            mode_d = dmr_mode_pkg::DMR_RESTORE;
          end
        end
      end
      dmr_mode_pkg::DMR_RESTORE: begin
        if (recovery_finished_i) begin
          mode_d = dmr_mode_pkg::DMR_RUN;
        end
      end
      default: ;
    endcase

    // Software controlled switching, later checks take priority
    if (`DMR_FIXED == 0) begin
      // Cores halted, mode tracks the enable bit
      if (!fetch_en_i) begin
        mode_d = dmr_enable_i ? dmr_mode_pkg::DMR_RUN : dmr_mode_pkg::NON_DMR;
      end
      // Split the pair on request
      if ((mode_q == dmr_mode_pkg::DMR_RUN) && !dmr_enable_i) begin
        mode_d = dmr_mode_pkg::NON_DMR;
      end
      // Join once the cores report they are in sync
      if ((mode_q == dmr_mode_pkg::NON_DMR) && cores_synch_i && dmr_enable_i) begin
        mode_d = dmr_mode_pkg::DMR_RUN;
      end
    end

    // Setback and recovery only go out with an actual restore entry
    restore_d = (mode_q == dmr_mode_pkg::DMR_RUN) && (mode_d == dmr_mode_pkg::DMR_RESTORE);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q             <= ResetMode;
      setback_o          <= 1'b0;
      recovery_request_o <= 1'b0;
      incr_mismatch_o    <= 1'b0;
    end else begin
      mode_q             <= mode_d;
      setback_o          <= restore_d;
      recovery_request_o <= restore_d;
      incr_mismatch_o    <= incr_d;
    end
  end

  assign mode_o = mode_q;

  // Restore is only reachable from lockstep run
  a_restore_from_run: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(mode_q == dmr_mode_pkg::DMR_RESTORE) |->
      ($past(mode_q) == dmr_mode_pkg::DMR_RUN));

  a_req_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    recovery_request_o |=> !recovery_request_o);

endmodule

`default_nettype wire

//--- source/dmr_mode_pkg.sv
/*
 * DMR mode package
 * Redundancy mode encoding and the payloads compared in lockstep
 */
`default_nettype none

`include "dmr_defines.svh"

package dmr_mode_pkg;

  // Redundancy mode of the core pair
  typedef enum logic [1:0] {
    NON_DMR,
    DMR_RUN,
    DMR_RESTORE
  } dmr_mode_e;

  // Instruction fetch address
  typedef logic [`DMR_ADDR_WIDTH-1:0] fetch_t;

  // One store transaction
  typedef struct packed {
    logic [`DMR_ADDR_WIDTH-1:0] addr;
    logic [`DMR_DATA_WIDTH-1:0] data;
    logic [3:0]                 be;
  } store_t;

endpackage

`default_nettype wire

//--- source/dmr_recovery_timer.sv
/*
 * DMR recovery timer
 * Times a restore after a recovery request and pulses its completion
 */
`timescale 1ns/1ps
`default_nettype none

`include "dmr_defines.svh"

module dmr_recovery_timer (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic start_i,
  output logic      busy_o,
  output logic      done_o
);

  localparam int CntW = $clog2(`DMR_RECOVERY_CYCLES + 1);

  logic [CntW-1:0] cnt_q;

  // Load on start, then count down to zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= CntW'(`DMR_RECOVERY_CYCLES);
    end else if (busy_o) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign busy_o = (cnt_q != '0);
  // Last count of the restore
  assign done_o = (cnt_q == CntW'(1));

  // The mode FSM must not request a second restore before this one ends
  a_no_start_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> !busy_o);

endmodule

`default_nettype wire

//--- source/dmr_reg_pkg.sv
/*
 * DMR register map package
 * Register offsets, bus word types and register field layouts
 */
`default_nettype none

package dmr_reg_pkg;

  typedef logic [3:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // Byte offsets of the registers
  localparam reg_addr_t REG_CTRL     = 4'h0;
  localparam reg_addr_t REG_STATUS   = 4'h4;
  localparam reg_addr_t REG_MISMATCH = 4'h8;

  // CTRL layout, bit 0 enables lockstep
  typedef struct packed {
    logic [30:0] rsvd;
    logic        enable;
  } ctrl_reg_t;

  // STATUS layout, low bits carry the current mode
  typedef struct packed {
    logic [29:0] rsvd;
    logic [1:0]  mode;
  } status_reg_t;

endpackage

`default_nettype wire

//--- verif/tb_clk_gen.sv
/*
 * Testbench clock and reset generator
 * Free running clock, active low reset released on a falling edge
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PeriodNs    = 4,
  parameter int ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- verif/tb_dmr_ctrl.sv
/*
 * DMR lockstep control testbench
 * Random register, mode and lockstep traffic checked against a cycle model
 */
`timescale 1ns/1ps
`default_nettype none

`include "dmr_defines.svh"

module tb_dmr_ctrl;

  localparam int PhaseRegCycles  = 400;
  localparam int PhaseModeCycles = 400;
  localparam int PhaseErrCycles  = 1200;
  localparam int TestCycles      = PhaseRegCycles + PhaseModeCycles + PhaseErrCycles + 1;
  localparam int ClkPeriodNs     = 4;
  localparam int TimeoutNs       = (TestCycles + 10 + 200) * ClkPeriodNs;
  localparam int RestoreLen      = `DMR_RECOVERY_CYCLES + 1;

  wire logic clk;
  wire logic rst_n;

  // DUT inputs
  logic                    reg_valid, reg_write;
  dmr_reg_pkg::reg_addr_t  reg_addr;
  dmr_reg_pkg::reg_data_t  reg_wdata;
  logic                    ext_enable, ext_enable_we, fetch_en, cores_synch;
  logic                    fetch_a_valid, fetch_b_valid, store_a_valid, store_b_valid;
  dmr_mode_pkg::fetch_t    fetch_a_addr, fetch_b_addr;
  dmr_mode_pkg::store_t    store_a, store_b;

  // DUT outputs
  dmr_reg_pkg::reg_data_t  reg_rdata;
  logic                    reg_rvalid, setback, recovery_request, grp_in_independent;
  dmr_mode_pkg::dmr_mode_e mode;

  // Model state, mirrors every register of the block
  dmr_mode_pkg::dmr_mode_e   m_mode;
  logic                      m_en, m_setback, m_rreq, m_incr, m_fmm, m_smm, m_rvalid;
  logic [`DMR_CNT_WIDTH-1:0] m_cnt;
  dmr_reg_pkg::reg_data_t    m_rdata;
  int                        m_tmr;
  int                        restore_len;

  tb_clk_gen #(.PeriodNs(ClkPeriodNs), .ResetCycles(10)) i_clk_gen (
    .clk_o(clk), .rst_no(rst_n)
  );

  dmr_ctrl_top UUT (
    .clk_i(clk), .rst_ni(rst_n),
    .reg_valid_i(reg_valid), .reg_write_i(reg_write), .reg_addr_i(reg_addr),
    .reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata), .reg_rvalid_o(reg_rvalid),
    .ext_enable_i(ext_enable), .ext_enable_we_i(ext_enable_we),
    .fetch_en_i(fetch_en), .cores_synch_i(cores_synch),
    .fetch_a_valid_i(fetch_a_valid), .fetch_a_addr_i(fetch_a_addr),
    .fetch_b_valid_i(fetch_b_valid), .fetch_b_addr_i(fetch_b_addr),
    .store_a_valid_i(store_a_valid), .store_a_i(store_a),
    .store_b_valid_i(store_b_valid), .store_b_i(store_b),
    .setback_o(setback), .recovery_request_o(recovery_request),
    .grp_in_independent_o(grp_in_independent), .mode_o(mode)
  );

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      stop_on_error($sformatf("Fail at %0t: %s expected %0h, actual %0h",
                              $time, name, exp, act));
    end
  endtask

  // Reset values of every modeled register
  task automatic model_reset();
    m_en        = 1'(`DMR_DEFAULT_ON);
    m_mode      = (`DMR_DEFAULT_ON != 0) ? dmr_mode_pkg::DMR_RUN : dmr_mode_pkg::NON_DMR;
    m_setback   = 1'b0;
    m_rreq      = 1'b0;
    m_incr      = 1'b0;
    m_fmm       = 1'b0;
    m_smm       = 1'b0;
    m_rvalid    = 1'b0;
    m_cnt       = '0;
    m_rdata     = '0;
    m_tmr       = 0;
    restore_len = 0;
  endtask

  function automatic dmr_reg_pkg::reg_data_t read_value(input dmr_reg_pkg::reg_addr_t addr);
    case (addr)
      dmr_reg_pkg::REG_CTRL:     return {31'b0, m_en};
      dmr_reg_pkg::REG_STATUS:   return {30'b0, 2'(m_mode)};
      dmr_reg_pkg::REG_MISMATCH: return 32'(m_cnt);
      default:                   return '0;
    endcase
  endfunction

  // One rising edge of the model, all next values from the old state
  task automatic model_step();
    dmr_mode_pkg::dmr_mode_e nxt;
    logic err, entering, incr_n;
    err = m_fmm || m_smm;
    nxt = m_mode;
    // Rule 1 and rule 2
    if ((m_mode == dmr_mode_pkg::DMR_RUN) && err && (`DMR_RAPID_RECOVERY != 0)) begin
      nxt = dmr_mode_pkg::DMR_RESTORE;
    end
    if ((m_mode == dmr_mode_pkg::DMR_RESTORE) && (m_tmr == 1)) begin
      nxt = dmr_mode_pkg::DMR_RUN;
    end
    // Rules 3 to 5 override
    if (`DMR_FIXED == 0) begin
      if (!fetch_en) begin
        nxt = m_en ? dmr_mode_pkg::DMR_RUN : dmr_mode_pkg::NON_DMR;
      end
      if ((m_mode == dmr_mode_pkg::DMR_RUN) && !m_en) begin
        nxt = dmr_mode_pkg::NON_DMR;
      end
      if ((m_mode == dmr_mode_pkg::NON_DMR) && cores_synch && m_en) begin
        nxt = dmr_mode_pkg::DMR_RUN;
      end
    end
    entering = (m_mode == dmr_mode_pkg::DMR_RUN) && (nxt == dmr_mode_pkg::DMR_RESTORE);
    // Only run-mode errors count
    incr_n = (m_mode == dmr_mode_pkg::DMR_RUN) && err;

    // Register port
    m_rvalid = reg_valid && !reg_write;
    if (m_rvalid) begin
      m_rdata = read_value(reg_addr);
    end
    if (reg_valid && reg_write && (reg_addr == dmr_reg_pkg::REG_MISMATCH)) begin
      m_cnt = '0;
    end else if (m_incr && (m_cnt != '1)) begin
      m_cnt = m_cnt + 1'b1;
    end
    if (ext_enable_we) begin
      m_en = ext_enable;
    end else if (reg_valid && reg_write && (reg_addr == dmr_reg_pkg::REG_CTRL)) begin
      m_en = reg_wdata[0];
    end

    // Restore timer
    if (m_rreq) begin
      m_tmr = `DMR_RECOVERY_CYCLES;
    end else if (m_tmr != 0) begin
      m_tmr = m_tmr - 1;
    end

    m_mode    = nxt;
    m_setback = entering;
    m_rreq    = entering;
    m_incr    = incr_n;

    // Comparators, payload only counts with both sides valid
    m_fmm = (fetch_a_valid ^ fetch_b_valid) ||
            (fetch_a_valid && fetch_b_valid && (fetch_a_addr != fetch_b_addr));
    m_smm = (store_a_valid ^ store_b_valid) ||
            (store_a_valid && store_b_valid && (store_a != store_b));
  endtask

  task automatic check_outputs();
    check_val("mode_o", 32'(m_mode), 32'(mode));
    check_val("grp_in_independent_o", 32'(m_mode == dmr_mode_pkg::NON_DMR),
              32'(grp_in_independent));
    check_val("setback_o", 32'(m_setback), 32'(setback));
    check_val("recovery_request_o", 32'(m_rreq), 32'(recovery_request));
    check_val("reg_rvalid_o", 32'(m_rvalid), 32'(reg_rvalid));
    if (m_rvalid) begin
      check_val("reg_rdata_o", m_rdata, reg_rdata);
    end
  endtask

  // Restore must span a fixed number of cycles
  task automatic track_restore();
    if (mode == dmr_mode_pkg::DMR_RESTORE) begin
      restore_len = restore_len + 1;
    end else begin
      if (restore_len != 0) begin
        check_val("restore length", RestoreLen, restore_len);
      end
      restore_len = 0;
    end
  endtask

  // New inputs for one cycle, percentages steer each kind of traffic
  task automatic drive_cycle(input int reg_pct, input int mm_pct, input int mode_pct);
    int bit_idx;
    logic halt_ok;
    halt_ok = (m_mode != dmr_mode_pkg::DMR_RESTORE) && (m_tmr == 0);
    reg_valid = ($urandom_range(99) < reg_pct);
    reg_write = 1'($urandom_range(1));
    reg_wdata = $urandom;
    case ($urandom_range(3))
      0:       reg_addr = dmr_reg_pkg::REG_CTRL;
      1:       reg_addr = dmr_reg_pkg::REG_STATUS;
      2:       reg_addr = dmr_reg_pkg::REG_MISMATCH;
      default: reg_addr = 4'($urandom);
    endcase
    ext_enable_we = ($urandom_range(99) < mode_pct);
    ext_enable    = ($urandom_range(3) != 0);
    cores_synch   = ($urandom_range(99) < 30);
    // Halting during a restore would cut the timer short
    fetch_en = !(halt_ok && ($urandom_range(99) < mode_pct / 2));

    // Matching pairs first
    fetch_a_valid = 1'($urandom_range(1));
    fetch_a_addr  = $urandom;
    store_a_valid = 1'($urandom_range(1));
    store_a.addr  = $urandom;
    store_a.data  = $urandom;
    store_a.be    = 4'($urandom);
    fetch_b_valid = fetch_a_valid;
    fetch_b_addr  = fetch_a_addr;
    store_b_valid = store_a_valid;
    store_b       = store_a;
    if ($urandom_range(99) < mm_pct) begin
      bit_idx = $urandom_range(31);
      case ($urandom_range(5))
        0: fetch_b_valid = ~fetch_b_valid;
        // May hit two idle sides, which must not flag
        1: fetch_b_addr[bit_idx] = ~fetch_b_addr[bit_idx];
        2: store_b_valid = ~store_b_valid;
        3: begin
          store_a_valid = 1'b1;
          store_b_valid = 1'b1;
          store_b.data[bit_idx] = ~store_b.data[bit_idx];
        end
        4: begin
          store_a_valid = 1'b1;
          store_b_valid = 1'b1;
          store_b.be[bit_idx % 4] = ~store_b.be[bit_idx % 4];
        end
        default: store_b.addr[bit_idx] = ~store_b.addr[bit_idx];
      endcase
    end
  endtask

  // Drive at the falling edge, model at the rising edge, check at the next fall
  task automatic run_phase(input int cycles, input int reg_pct, input int mm_pct,
                           input int mode_pct);
    repeat (cycles) begin
      drive_cycle(reg_pct, mm_pct, mode_pct);
      @(posedge clk);
      model_step();
      @(negedge clk);
      check_outputs();
      track_restore();
    end
  endtask

  initial begin
    reg_valid     = 1'b0;
    reg_write     = 1'b0;
    reg_addr      = '0;
    reg_wdata     = '0;
    ext_enable    = 1'b0;
    ext_enable_we = 1'b0;
    fetch_en      = 1'b1;
    cores_synch   = 1'b0;
    fetch_a_valid = 1'b0;
    fetch_b_valid = 1'b0;
    fetch_a_addr  = '0;
    fetch_b_addr  = '0;
    store_a_valid = 1'b0;
    store_b_valid = 1'b0;
    store_a       = '0;
    store_b       = '0;
    void'($urandom(32'hb6b4));
    model_reset();

    @(posedge rst_n);
    // Reset state
    check_outputs();

    // Counter reads zero straight out of reset
    reg_valid = 1'b1;
    reg_addr  = dmr_reg_pkg::REG_MISMATCH;
    @(posedge clk);
    model_step();
    @(negedge clk);
    check_outputs();
    check_val("REG_MISMATCH after reset", 32'h0, reg_rdata);

    run_phase(PhaseRegCycles, 80, 0, 20);
    run_phase(PhaseModeCycles, 20, 0, 30);
    run_phase(PhaseErrCycles, 10, 15, 5);

    $display("Simulation finished: PASS");
    $finish;
  end

  // Watchdog
  initial begin
    #(TimeoutNs);
    $display("Timeout: the test did not finish within %0d ns", TimeoutNs);
    $display("Simulation finished: FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire
